/* list.f */
src/uart_pkg.sv
src/uart_baud_tick.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart_top.sv
verification/uart_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module uart_tb \
	-Mdir obj_dir -o uart_sim > build.log 2>&1 \
	&& ./obj_dir/uart_sim > sim.log 2>&1 \
	|| { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -qx "TEST PASS" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

/* verification/uart_tb.sv */
`timescale 1ns/1ns

module uart_tb;

	// Line timing as the serial link sees it
	localparam int cycles_per_bit = uart_pkg::clocks_per_tick * uart_pkg::ticks_per_bit;
	localparam int cycles_per_frame = 10 * cycles_per_bit;
	// A frame plus the wait for the first tick, with a little slack
	localparam int busy_limit = 11 * cycles_per_bit + 8;
	// Rough frame budget of all tests together, idle gaps counted as frames
	localparam int frame_budget = 30;
	localparam int watchdog_ns = (frame_budget + 10) * cycles_per_frame * 10;

	logic clk;
	logic reset;
	logic rx;
	uart_pkg::uart_char_t rx_char;
	logic rx_char_valid;
	logic rx_frame_error;
	uart_pkg::uart_char_t tx_char;
	logic tx_start;
	logic tx;
	logic tx_busy;

	// High routes the DUT tx back into its rx, low hands rx to the bit-bang driver
	logic loopback;
	logic bitbang_line;

	int errors = 0;
	int valid_count = 0;
	int frame_error_count = 0;
	uart_pkg::uart_char_t rx_log[$];
	// Last character that the transmitter accepted, the one rx_char should hold afterwards
	uart_pkg::uart_char_t last_tx_char;

	assign rx = loopback ? tx : bitbang_line;

	uart_top uut
	(
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.rx_char(rx_char),
		.rx_char_valid(rx_char_valid),
		.rx_frame_error(rx_frame_error),
		.tx_char(tx_char),
		.tx_start(tx_start),
		.tx(tx),
		.tx_busy(tx_busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		#(watchdog_ns);
		$display("Watchdog expired before all tests had finished");
		$display("TEST FAIL");
		$finish;
	end

	// Counts every strobe and logs each received character in arrival order
	always @(posedge clk)
	begin
		if (rx_char_valid)
		begin
			valid_count = valid_count + 1;
			rx_log.push_back(rx_char);
		end
		if (rx_frame_error)
			frame_error_count = frame_error_count + 1;
	end

	// Advances whole cycles and lands 1 ns after the rising edge
	task automatic step(input int cycles);
		repeat (cycles)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic report_mismatch(input string name, input int expected, input int actual);
		$display("ERROR at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
		errors = errors + 1;
	endtask

	task automatic report_failure(input string what);
		$display("Failure at %0t ns: %s", $time, what);
		errors = errors + 1;
	endtask

	task automatic wait_busy_low(input int max_cycles);
		int waited;
		waited = 0;
		while (tx_busy && waited < max_cycles)
		begin
			step(1);
			waited = waited + 1;
		end
		if (tx_busy)
			report_failure("tx_busy did not fall within the frame time");
	endtask

	task automatic wait_valid(input int target, input int max_cycles);
		int waited;
		waited = 0;
		while (valid_count < target && waited < max_cycles)
		begin
			step(1);
			waited = waited + 1;
		end
		if (valid_count < target)
			report_failure("rx_char_valid did not pulse before the timeout");
	endtask

	task automatic wait_frame_error(input int target, input int max_cycles);
		int waited;
		waited = 0;
		while (frame_error_count < target && waited < max_cycles)
		begin
			step(1);
			waited = waited + 1;
		end
		if (frame_error_count < target)
			report_failure("rx_frame_error did not pulse before the timeout");
	endtask

	// One-cycle strobe with no regard for tx_busy
	task automatic pulse_start(input uart_pkg::uart_char_t c);
		tx_char = c;
		tx_start = 1'b1;
		step(1);
		tx_start = 1'b0;
	endtask

	// Waits for the transmitter to go idle, so the strobe is accepted
	task automatic start_tx(input uart_pkg::uart_char_t c);
		wait_busy_low(busy_limit);
		pulse_start(c);
		last_tx_char = c;
	endtask

	// Bit-bangs start, eight data bits LSB first and a stop bit of chosen level and length
	task automatic send_bits(input uart_pkg::uart_char_t c, input logic stop_level,
		input int stop_cycles);
		bitbang_line = 1'b0;
		step(cycles_per_bit);
		for (int i = 0; i < 8; i++)
		begin
			bitbang_line = c[i];
			step(cycles_per_bit);
		end
		bitbang_line = stop_level;
		step(stop_cycles);
		bitbang_line = 1'b1;
	endtask

	task automatic check_reset_state();
		reset = 1'b1;
		step(4);
		if (tx !== 1'b1)
			report_mismatch("tx", 1, int'(tx));
		if (tx_busy !== 1'b0)
			report_mismatch("tx_busy", 0, int'(tx_busy));
		reset = 1'b0;
		step(8);
		if (tx !== 1'b1)
			report_mismatch("tx", 1, int'(tx));
		if (tx_busy !== 1'b0)
			report_mismatch("tx_busy", 0, int'(tx_busy));
		if (rx_char !== 8'h00)
			report_mismatch("rx_char", 0, int'(rx_char));
		if (valid_count != 0 || frame_error_count != 0)
			report_failure("a receive strobe pulsed around reset");
	endtask

	task automatic loopback_fixed_chars();
		uart_pkg::uart_char_t fixed [5];
		int before_valid;
		int before_error;
		fixed = '{8'h00, 8'hFF, 8'h55, 8'hA5, 8'h80};
		loopback = 1'b1;
		foreach (fixed[i])
		begin
			before_valid = valid_count;
			before_error = frame_error_count;
			start_tx(fixed[i]);
			wait_busy_low(busy_limit);
			wait_valid(before_valid + 1, cycles_per_bit);
			if (valid_count != before_valid + 1)
				report_mismatch("rx_char_valid count", before_valid + 1, valid_count);
			if (rx_char !== fixed[i])
				report_mismatch("rx_char", int'(fixed[i]), int'(rx_char));
			if (frame_error_count != before_error)
				report_mismatch("rx_frame_error count", before_error, frame_error_count);
		end
	endtask

	task automatic loopback_random_chars();
		uart_pkg::uart_char_t sent[$];
		uart_pkg::uart_char_t c;
		int first;
		int before_valid;
		first = rx_log.size();
		before_valid = valid_count;
		loopback = 1'b1;
		// Each frame starts as soon as the previous one has released tx_busy
		for (int i = 0; i < 20; i++)
		begin
			c = uart_pkg::uart_char_t'($urandom());
			sent.push_back(c);
			start_tx(c);
		end
		wait_busy_low(busy_limit);
		wait_valid(before_valid + 20, cycles_per_frame);
		if (rx_log.size() != first + 20)
			report_mismatch("received character count", 20, rx_log.size() - first);
		for (int i = 0; i < 20 && first + i < rx_log.size(); i++)
		begin
			if (rx_log[first + i] !== sent[i])
				report_mismatch("rx_char in sequence", int'(sent[i]), int'(rx_log[first + i]));
		end
	endtask

	task automatic framing_error_frame();
		uart_pkg::uart_char_t prev;
		int before_valid;
		int before_error;
		bitbang_line = 1'b1;
		loopback = 1'b0;
		step(cycles_per_bit);
		prev = last_tx_char;
		before_valid = valid_count;
		before_error = frame_error_count;
		// The line comes back high three quarters into the stop bit.
		// The receiver still samples it low at mid-bit, and the restart that the
		// low tail triggers is dropped as a glitch at its own middle
		send_bits(8'h96, 1'b0, 3 * cycles_per_bit / 4);
		step(2 * cycles_per_bit);
		wait_frame_error(before_error + 1, cycles_per_bit);
		if (frame_error_count != before_error + 1)
			report_mismatch("rx_frame_error count", before_error + 1, frame_error_count);
		if (valid_count != before_valid)
			report_mismatch("rx_char_valid count", before_valid, valid_count);
		if (rx_char !== prev)
			report_mismatch("rx_char", int'(prev), int'(rx_char));
	endtask

	task automatic start_glitch_rejection();
		int before_valid;
		int before_error;
		loopback = 1'b0;
		before_valid = valid_count;
		before_error = frame_error_count;
		// Three ticks low, well short of mid start bit
		bitbang_line = 1'b0;
		step(12);
		bitbang_line = 1'b1;
		step(2 * cycles_per_bit);
		if (valid_count != before_valid || frame_error_count != before_error)
			report_failure("a short low pulse on rx produced a receive strobe");
		send_bits(8'h3C, 1'b1, cycles_per_bit);
		wait_valid(before_valid + 1, cycles_per_bit);
		if (valid_count != before_valid + 1)
			report_mismatch("rx_char_valid count", before_valid + 1, valid_count);
		if (rx_char !== 8'h3C)
			report_mismatch("rx_char", 'h3C, int'(rx_char));
		if (frame_error_count != before_error)
			report_mismatch("rx_frame_error count", before_error, frame_error_count);
	endtask

	task automatic start_while_busy();
		int before_valid;
		int before_error;
		loopback = 1'b1;
		before_valid = valid_count;
		before_error = frame_error_count;
		start_tx(8'hC3);
		step(5 * cycles_per_bit);
		if (tx_busy !== 1'b1)
			report_mismatch("tx_busy", 1, int'(tx_busy));
		// This strobe lands mid-frame and must be dropped
		pulse_start(8'h3A);
		wait_busy_low(busy_limit);
		step(cycles_per_frame);
		if (tx_busy !== 1'b0)
			report_mismatch("tx_busy", 0, int'(tx_busy));
		if (valid_count != before_valid + 1)
			report_mismatch("rx_char_valid count", before_valid + 1, valid_count);
		if (rx_char !== 8'hC3)
			report_mismatch("rx_char", 'hC3, int'(rx_char));
		if (frame_error_count != before_error)
			report_mismatch("rx_frame_error count", before_error, frame_error_count);
	endtask

	initial
	begin
		int seed_result;
		seed_result = $urandom(23);
		reset = 1'b1;
		loopback = 1'b0;
		bitbang_line = 1'b1;
		tx_char = '0;
		tx_start = 1'b0;
		last_tx_char = '0;

		check_reset_state();
		loopback_fixed_chars();
		loopback_random_chars();
		framing_error_frame();
		start_glitch_rejection();
		start_while_busy();

		$display("Done with %0d errors, %0d characters received, %0d framing errors",
			errors, valid_count, frame_error_count);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* src/uart_top.sv */
`timescale 1ns/1ns

module uart_top
(
	input  logic                clk,
	input  logic                reset,
	input  logic                rx,
	output uart_pkg::uart_char_t rx_char,
	output logic                rx_char_valid,
	output logic                rx_frame_error,
	input  uart_pkg::uart_char_t tx_char,
	input  logic                tx_start,
	output logic                tx,
	output logic                tx_busy
);

	// One oversampling tick paces both directions
	logic tick;

	uart_baud_tick baud_tick
	(
		.clk(clk),
		.reset(reset),
		.tick(tick)
	);

	// Receive path from the rx pin to the character strobes
	uart_rx receiver
	(
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.rx(rx),
		.rx_char(rx_char),
		.rx_char_valid(rx_char_valid),
		.rx_frame_error(rx_frame_error)
	);

	// Transmit path from the start strobe to the tx pin
	uart_tx transmitter
	(
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.tx_char(tx_char),
		.tx_start(tx_start),
		.tx(tx),
		.tx_busy(tx_busy)
	);

endmodule

/* src/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx
(
	input  logic                clk,
	input  logic                reset,
	input  logic                tick,
	input  uart_pkg::uart_char_t tx_char,
	input  logic                tx_start,
	output logic                tx,
	output logic                tx_busy
);

	localparam uart_pkg::tick_count_t bit_last = uart_pkg::tick_count_t'(uart_pkg::ticks_per_bit - 1);
	localparam uart_pkg::bit_index_t last_data_bit =
		uart_pkg::bit_index_t'($bits(uart_pkg::uart_char_t) - 1);

	uart_pkg::tx_state_t state_ff;
	uart_pkg::tx_state_t state_nxt;
	uart_pkg::tick_count_t tick_count_ff;
	uart_pkg::tick_count_t tick_count_nxt;
	uart_pkg::bit_index_t bit_index_ff;
	uart_pkg::bit_index_t bit_index_nxt;
	uart_pkg::uart_char_t shift_reg;
	logic tx_nxt;
	logic load;
	logic do_shift;

	always_comb
	begin
		state_nxt = state_ff;
		tick_count_nxt = tick_count_ff;
		bit_index_nxt = bit_index_ff;
		tx_nxt = tx;
		load = 1'b0;
		do_shift = 1'b0;

		case (state_ff)
			uart_pkg::tx_idle:
			begin
				tx_nxt = 1'b1;
				if (tx_start)
				begin
					load = 1'b1;
					state_nxt = uart_pkg::tx_start_bit;
					tick_count_nxt = '0;
				end
			end

			uart_pkg::tx_start_bit:
			begin
				if (tick)
				begin
					// Line still high means the frame has not begun, so this tick
					// drops the line and the start bit is counted from here
					if (tx)
						tx_nxt = 1'b0;
					else if (tick_count_ff == bit_last)
					begin
						state_nxt = uart_pkg::tx_data_bits;
						tick_count_nxt = '0;
						bit_index_nxt = '0;
						tx_nxt = shift_reg[0];
					end
					else
						tick_count_nxt = tick_count_ff + 1'b1;
				end
			end

			uart_pkg::tx_data_bits:
			begin
				if (tick)
				begin
					if (tick_count_ff == bit_last)
					begin
						tick_count_nxt = '0;
						if (bit_index_ff == last_data_bit)
						begin
							state_nxt = uart_pkg::tx_stop_bit;
							tx_nxt = 1'b1;
						end
						else
						begin
							// Next bit sits one place up before the shift takes effect
							do_shift = 1'b1;
							bit_index_nxt = bit_index_ff + 1'b1;
							tx_nxt = shift_reg[1];
						end
					end
					else
						tick_count_nxt = tick_count_ff + 1'b1;
				end
			end

			uart_pkg::tx_stop_bit:
			begin
				// The stop bit runs its full 16 ticks before the next frame may start
				if (tick)
				begin
					if (tick_count_ff == bit_last)
						state_nxt = uart_pkg::tx_idle;
					else
						tick_count_nxt = tick_count_ff + 1'b1;
				end
			end

			default:
				state_nxt = uart_pkg::tx_idle;
		endcase
	end

	// tx comes straight from a flop so the line never glitches
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state_ff <= uart_pkg::tx_idle;
			tick_count_ff <= '0;
			bit_index_ff <= '0;
			tx <= 1'b1;
		end
		else
		begin
			state_ff <= state_nxt;
			tick_count_ff <= tick_count_nxt;
			bit_index_ff <= bit_index_nxt;
			tx <= tx_nxt;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
			shift_reg <= tx_char;
		else if (do_shift)
			shift_reg <= {1'b0, shift_reg[7:1]};
	end

	// Busy for the whole frame, including the wait for the first tick
	assign tx_busy = (state_ff != uart_pkg::tx_idle);

	// Outside a frame the line must rest at the idle level
	idle_line_high: assert property (@(posedge clk) disable iff (reset) !tx_busy |-> tx)
		else $error("tx low while transmitter idle");

endmodule

/* src/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx
(
	input  logic                clk,
	input  logic                reset,
	input  logic                tick,
	input  logic                rx,
	output uart_pkg::uart_char_t rx_char,
	output logic                rx_char_valid,
	output logic                rx_frame_error
);

	// Tick count at the end of a full bit, and at the middle of the start bit
	localparam uart_pkg::tick_count_t bit_last = uart_pkg::tick_count_t'(uart_pkg::ticks_per_bit - 1);
	localparam uart_pkg::tick_count_t half_bit_last =
		uart_pkg::tick_count_t'(uart_pkg::ticks_per_bit / 2 - 1);
	localparam uart_pkg::bit_index_t last_data_bit =
		uart_pkg::bit_index_t'($bits(uart_pkg::uart_char_t) - 1);

	logic rx_sync0;
	logic rx_sync1;
	uart_pkg::rx_state_t state_ff;
	uart_pkg::rx_state_t state_nxt;
	uart_pkg::tick_count_t tick_count_ff;
	uart_pkg::tick_count_t tick_count_nxt;
	uart_pkg::bit_index_t bit_index_ff;
	uart_pkg::bit_index_t bit_index_nxt;
	uart_pkg::uart_char_t shift_reg;
	logic do_shift;
	logic char_done;
	logic stop_bad;

	// Two-flop synchronizer for the asynchronous line.
	// Reset to the idle level so no false start bit is seen coming out of reset
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rx_sync0 <= 1'b1;
			rx_sync1 <= 1'b1;
		end
		else
		begin
			rx_sync0 <= rx;
			rx_sync1 <= rx_sync0;
		end
	end

	always_comb
	begin
		state_nxt = state_ff;
		tick_count_nxt = tick_count_ff;
		bit_index_nxt = bit_index_ff;
		do_shift = 1'b0;
		char_done = 1'b0;
		stop_bad = 1'b0;

		case (state_ff)
			uart_pkg::rx_idle:
			begin
				// A falling edge may be a start bit, count ticks from here
				if (!rx_sync1)
				begin
					state_nxt = uart_pkg::rx_start_bit;
					tick_count_nxt = '0;
				end
			end

			uart_pkg::rx_start_bit:
			begin
				if (tick)
				begin
					if (tick_count_ff == half_bit_last)
					begin
						// Line back high at mid start bit means it was only a glitch
						if (rx_sync1)
							state_nxt = uart_pkg::rx_idle;
						else
						begin
							state_nxt = uart_pkg::rx_data_bits;
							tick_count_nxt = '0;
							bit_index_nxt = '0;
						end
					end
					else
						tick_count_nxt = tick_count_ff + 1'b1;
				end
			end

			uart_pkg::rx_data_bits:
			begin
				if (tick)
				begin
					// Full bit period after the previous sample lands mid-bit
					if (tick_count_ff == bit_last)
					begin
						do_shift = 1'b1;
						tick_count_nxt = '0;
						if (bit_index_ff == last_data_bit)
							state_nxt = uart_pkg::rx_stop_bit;
						else
							bit_index_nxt = bit_index_ff + 1'b1;
					end
					else
						tick_count_nxt = tick_count_ff + 1'b1;
				end
			end

			uart_pkg::rx_stop_bit:
			begin
				if (tick)
				begin
					// Decide at mid stop bit and go idle at once so the next
					// start edge of a back-to-back frame is not missed
					if (tick_count_ff == bit_last)
					begin
						state_nxt = uart_pkg::rx_idle;
						if (rx_sync1)
							char_done = 1'b1;
						else
							stop_bad = 1'b1;
					end
					else
						tick_count_nxt = tick_count_ff + 1'b1;
				end
			end

			default:
				state_nxt = uart_pkg::rx_idle;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state_ff <= uart_pkg::rx_idle;
			tick_count_ff <= '0;
			bit_index_ff <= '0;
			rx_char <= '0;
			rx_char_valid <= 1'b0;
			rx_frame_error <= 1'b0;
		end
		else
		begin
			state_ff <= state_nxt;
			tick_count_ff <= tick_count_nxt;
			bit_index_ff <= bit_index_nxt;
			rx_char_valid <= char_done;
			rx_frame_error <= stop_bad;
			// The output keeps the last good character, a bad frame leaves it alone
			if (char_done)
				rx_char <= shift_reg;
		end
	end

	// Data arrives LSB first, so shift right and enter at the top
	always_ff @(posedge clk)
	begin
		if (do_shift)
			shift_reg <= {rx_sync1, shift_reg[7:1]};
	end

	// A frame ends in exactly one of the two outcomes
	valid_xor_error: assert property (@(posedge clk) disable iff (reset)
		!(rx_char_valid && rx_frame_error))
		else $error("rx_char_valid and rx_frame_error high together");

endmodule

/* src/uart_baud_tick.sv */
`timescale 1ns/1ns

module uart_baud_tick
(
	input  logic clk,
	input  logic reset,
	output logic tick
);

	// Divider width comes from the package constant, with room for the reload value
	localparam int div_width = $clog2(uart_pkg::clocks_per_tick + 1);
	localparam logic [div_width-1:0] div_reload = div_width'(uart_pkg::clocks_per_tick - 1);

	logic [div_width-1:0] divider;

	// Down-counter that reloads when it reaches zero.
	// The tick is registered, so it is high for the cycle after the counter hits zero.
	// Starting from the reload value puts the first tick clocks_per_tick cycles
	// after reset is released
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divider <= div_reload;
			tick <= 1'b0;
		end
		else if (divider == '0)
		begin
			divider <= div_reload;
			tick <= 1'b1;
		end
		else
		begin
			divider <= divider - 1'b1;
			tick <= 1'b0;
		end
	end

	// Both the receiver and transmitter count ticks as single events, so a tick
	// that stays high for two cycles would be counted twice
	tick_single_cycle: assert property (@(posedge clk) disable iff (reset) tick |=> !tick)
		else $error("tick held high for more than one cycle");

endmodule

/* src/uart_pkg.sv */
package uart_pkg;

	// Number of clk cycles in one oversampling tick.
	// With 16 ticks per bit this gives 64 cycles per bit and 640 per 8N1 frame
	localparam int clocks_per_tick = 4;

	// Oversampling ticks per serial bit.
	// The receiver samples at the middle of each bit, half of this count in
	localparam int ticks_per_bit = 16;

	// One character on the line, sent and received LSB first
	typedef logic [7:0] uart_char_t;

	// Counts ticks inside one bit period
	typedef logic [3:0] tick_count_t;

	// Selects one of the eight data bits of a frame
	typedef logic [2:0] bit_index_t;

	// Receiver FSM states.
	// Start bit is qualified at its middle before data sampling begins
	typedef enum logic [1:0]
	{
		rx_idle,
		rx_start_bit,
		rx_data_bits,
		rx_stop_bit
	} rx_state_t;

	// Transmitter FSM states.
	// The start bit state also covers the wait for the first tick after acceptance
	typedef enum logic [1:0]
	{
		tx_idle,
		tx_start_bit,
		tx_data_bits,
		tx_stop_bit
	} tx_state_t;

endpackage
